// File: alarm_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module alarm_arbiter (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  stereo_alarm_pkg::severity_t  [stereo_alarm_pkg::NUM_ZONES-1:0] severity,
    output logic [stereo_alarm_pkg::NUM_ZONES-1:0] led,
    output logic                         buzz
);
    import stereo_alarm_pkg::*;

    severity_t         max_sev;
    logic [TONE_W-1:0] tone_cnt;
    logic              tone;
    logic [BEEP_W-1:0] beep_cnt;
    logic [BEEP_W-1:0] beep_last;
    logic              gate_on;

    // worst severity over all zones
    always_comb begin
        max_sev = SEV_QUIET;
        for (int i = 0; i < NUM_ZONES; i++) begin
            if (severity[i] > max_sev) begin
                max_sev = severity[i];
            end
        end
    end

    // danger beeps fast, warn beeps slow
    assign beep_last = (max_sev == SEV_DANGER) ? BEEP_W'(BEEP_FAST - 1) : BEEP_W'(BEEP_SLOW - 1);
    assign gate_on   = (beep_cnt <= (beep_last >> 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            led <= '0;
        end else begin
            for (int i = 0; i < NUM_ZONES; i++) begin
                led[i] <= (severity[i] != SEV_QUIET);
            end
        end
    end

    // free-running tone, toggles every TONE_HALF cycles
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tone_cnt <= '0;
            tone     <= 1'b0;
        end else if (tone_cnt == TONE_W'(TONE_HALF - 1)) begin
            tone_cnt <= '0;
            tone     <= ~tone;
        end else begin
            tone_cnt <= tone_cnt + 1'b1;
        end
    end

    // beep gate, also wraps early if the period shrinks mid-count
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            beep_cnt <= '0;
        end else if (beep_cnt >= beep_last) begin
            beep_cnt <= '0;
        end else begin
            beep_cnt <= beep_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            buzz <= 1'b0;
        end else begin
            buzz <= tone && gate_on && (max_sev != SEV_QUIET);
        end
    end

endmodule

`default_nettype wire

// File: heat_palette.sv
`timescale 1ns/10ps
`default_nettype none

module heat_palette #(
    parameter type code_t = stereo_alarm_pkg::hamming_t,
    parameter code_t [stereo_alarm_pkg::HEAT_BINS-1:0] EDGES =
        stereo_alarm_pkg::HAMMING_EDGES
) (
    input  code_t                     code,
    output stereo_alarm_pkg::rgb565_t color
);
    import stereo_alarm_pkg::*;

    // walk from the near end down so the lowest matching bin wins
    always_comb begin
        color = COLOR_BLACK;
        for (int i = HEAT_BINS - 1; i >= 0; i--) begin
            if (code <= EDGES[i]) begin
                color = HEAT_COLORS[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: quadrant_compositor.sv
`timescale 1ns/10ps
`default_nettype none

module quadrant_compositor (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  stereo_alarm_pkg::coord_t         x_pixel,
    input  stereo_alarm_pkg::coord_t         y_pixel,
    input  stereo_alarm_pkg::gray_t          gray_left,
    input  stereo_alarm_pkg::gray_t          gray_right,
    input  stereo_alarm_pkg::hamming_t       hamming,
    input  stereo_alarm_pkg::sad_t           sad,
    output stereo_alarm_pkg::rgb565_t        rgb,
    output stereo_alarm_pkg::pixel_class_t   pix_class
);
    import stereo_alarm_pkg::*;

    logic    active;
    logic    left_half;
    logic    top_half;
    rgb565_t ham_color;
    rgb565_t sad_color;
    rgb565_t lower_color;
    rgb565_t pixel_color;

    heat_palette #(
        .code_t (hamming_t),
        .EDGES  (HAMMING_EDGES)
    ) u_ham_palette (
        .code   (hamming),
        .color  (ham_color)
    );

    heat_palette #(
        .code_t (sad_t),
        .EDGES  (SAD_EDGES)
    ) u_sad_palette (
        .code   (sad),
        .color  (sad_color)
    );

    assign active    = (x_pixel < coord_t'(H_ACTIVE)) && (y_pixel < coord_t'(V_ACTIVE));
    assign left_half = (x_pixel < coord_t'(QUAD_W));
    assign top_half  = (y_pixel < coord_t'(QUAD_H));

    // census map on the left, sad map on the right
    assign lower_color = left_half ? ham_color : sad_color;

    // gray spread over 5/6/5 fields
    always_comb begin
        if (!top_half) begin
            pixel_color = lower_color;
        end else if (left_half) begin
            pixel_color = {gray_left[7:3], gray_left[7:2], gray_left[7:3]};
        end else begin
            pixel_color = {gray_right[7:3], gray_right[7:2], gray_right[7:3]};
        end
    end

    // near classes only come from the heat maps
    always_comb begin
        pix_class = CLASS_NONE;
        if (active && !top_half) begin
            case (lower_color)
                COLOR_BLACK:  pix_class = CLASS_BLACK;
                COLOR_ORANGE: pix_class = CLASS_ORANGE;
                COLOR_RED:    pix_class = CLASS_RED;
                default:      pix_class = CLASS_NONE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rgb <= COLOR_BLACK;
        end else begin
            rgb <= active ? pixel_color : COLOR_BLACK;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the stereo_alarm testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f stereo_alarm.f --top-module tb_stereo_alarm
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_stereo_alarm)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation PASSED"; then
    exit 0
fi

echo "pass line not found in simulation output"
exit 1

// File: stereo_alarm.f
stereo_alarm_pkg.sv
vga_scan.sv
heat_palette.sv
quadrant_compositor.sv
zone_monitor.sv
alarm_arbiter.sv
stereo_alarm_top.sv
tb_clock_gen.sv
tb_stereo_alarm.sv

// File: stereo_alarm_pkg.sv
`default_nettype none

package stereo_alarm_pkg;

    // 640x480 scan timing, counted in pixel clocks
    localparam int H_ACTIVE     = 640;
    localparam int H_TOTAL      = 800;
    localparam int H_SYNC_START = 656;
    localparam int H_SYNC_END   = 751;
    localparam int V_ACTIVE     = 480;
    localparam int V_TOTAL      = 525;
    localparam int V_SYNC_START = 490;
    localparam int V_SYNC_END   = 491;

    localparam int QUAD_W = 320;
    localparam int QUAD_H = 240;

    typedef logic [9:0]  coord_t;
    typedef logic [7:0]  gray_t;
    typedef logic [15:0] rgb565_t;
    typedef logic [5:0]  hamming_t;
    typedef logic [4:0]  sad_t;
    typedef logic [15:0] count_t;

    localparam rgb565_t COLOR_BLUE   = 16'b00000_000000_11111;
    localparam rgb565_t COLOR_CYAN   = 16'b00000_111111_11111;
    localparam rgb565_t COLOR_GREEN  = 16'b00000_111111_00000;
    localparam rgb565_t COLOR_YELLOW = 16'b11111_111111_00000;
    localparam rgb565_t COLOR_ORANGE = 16'b11111_100000_00000;
    localparam rgb565_t COLOR_RED    = 16'b11111_000000_00000;
    localparam rgb565_t COLOR_BLACK  = 16'b00000_000000_00000;

    // heat bins, index 0 is the far (blue) end
    localparam int HEAT_BINS = 6;
    localparam rgb565_t [HEAT_BINS-1:0] HEAT_COLORS = {
        COLOR_RED, COLOR_ORANGE, COLOR_YELLOW, COLOR_GREEN, COLOR_CYAN, COLOR_BLUE
    };
    // highest code of each bin, anything above the last edge is black
    localparam hamming_t [HEAT_BINS-1:0] HAMMING_EDGES = {
        6'd44, 6'd37, 6'd31, 6'd24, 6'd16, 6'd12
    };
    localparam sad_t [HEAT_BINS-1:0] SAD_EDGES = {
        5'd24, 5'd20, 5'd15, 5'd10, 5'd6, 5'd3
    };

    typedef enum logic [1:0] {
        CLASS_NONE   = 2'd0,
        CLASS_BLACK  = 2'd1,
        CLASS_ORANGE = 2'd2,
        CLASS_RED    = 2'd3
    } pixel_class_t;

    typedef enum logic [1:0] {
        SEV_QUIET  = 2'd0,
        SEV_WARN   = 2'd2,
        SEV_DANGER = 2'd3
    } severity_t;

    // watch windows, bounds inclusive
    localparam int NUM_ZONES = 2;
    localparam coord_t [NUM_ZONES-1:0] ZONE_X_LO = {10'd361, 10'd41};
    localparam coord_t [NUM_ZONES-1:0] ZONE_X_HI = {10'd599, 10'd279};
    localparam coord_t ZONE_Y_LO = 10'd270;
    localparam coord_t ZONE_Y_HI = 10'd449;

    localparam count_t BLACK_LIMIT  = 16'd1500;
    localparam count_t ORANGE_LIMIT = 16'd1200;
    localparam count_t RED_LIMIT    = 16'd1000;

    // buzzer timing in clock cycles
    localparam int TONE_HALF = 4;
    localparam int BEEP_FAST = 256;
    localparam int BEEP_SLOW = 1024;
    localparam int TONE_W    = $clog2(TONE_HALF);
    localparam int BEEP_W    = $clog2(BEEP_SLOW);

endpackage

`default_nettype wire

// File: stereo_alarm_top.sv
`timescale 1ns/10ps
`default_nettype none

module stereo_alarm_top (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  stereo_alarm_pkg::gray_t                  gray_left,
    input  stereo_alarm_pkg::gray_t                  gray_right,
    input  stereo_alarm_pkg::hamming_t               hamming,
    input  stereo_alarm_pkg::sad_t                   sad,
    output stereo_alarm_pkg::coord_t                 x_pixel,
    output stereo_alarm_pkg::coord_t                 y_pixel,
    output logic                                     h_sync,
    output logic                                     v_sync,
    output stereo_alarm_pkg::rgb565_t                rgb,
    output logic [stereo_alarm_pkg::NUM_ZONES-1:0]   led,
    output logic                                     buzz
);
    import stereo_alarm_pkg::*;

    pixel_class_t                  pix_class;
    severity_t [NUM_ZONES-1:0]     zone_severity;

    vga_scan u_vga_scan (
        .clk        (clk),
        .reset      (reset),
        .x_pixel    (x_pixel),
        .y_pixel    (y_pixel),
        .h_sync     (h_sync),
        .v_sync     (v_sync)
    );

    quadrant_compositor u_quadrant_compositor (
        .clk        (clk),
        .reset      (reset),
        .x_pixel    (x_pixel),
        .y_pixel    (y_pixel),
        .gray_left  (gray_left),
        .gray_right (gray_right),
        .hamming    (hamming),
        .sad        (sad),
        .rgb        (rgb),
        .pix_class  (pix_class)
    );

    // one monitor per lower quadrant window
    for (genvar g = 0; g < NUM_ZONES; g++) begin : g_zone
        zone_monitor #(
            .ZONE       (g)
        ) u_zone_monitor (
            .clk        (clk),
            .reset      (reset),
            .x_pixel    (x_pixel),
            .y_pixel    (y_pixel),
            .pix_class  (pix_class),
            .severity   (zone_severity[g])
        );
    end

    alarm_arbiter u_alarm_arbiter (
        .clk        (clk),
        .reset      (reset),
        .severity   (zone_severity),
        .led        (led),
        .buzz       (buzz)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // release shortly after a falling edge, away from both clock edges
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        #(PERIOD / 10) reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: tb_stereo_alarm.sv
`timescale 1ns/10ps
`default_nettype none

module tb_stereo_alarm;
    import stereo_alarm_pkg::*;

    localparam int CYCLE_LIMIT = 3 * H_TOTAL * V_TOTAL + 100;

    // heat bins from the blue end up
    localparam int HAM_EDGE [6] = '{12, 16, 24, 31, 37, 44};
    localparam int SAD_EDGE [6] = '{3, 6, 10, 15, 20, 24};
    localparam rgb565_t HEAT [6] = '{COLOR_BLUE, COLOR_CYAN, COLOR_GREEN,
                                     COLOR_YELLOW, COLOR_ORANGE, COLOR_RED};

    // window codes of frames A, B and C
    localparam hamming_t FRAME_HAM [3] = '{6'd50, 6'd5, 6'd5};
    localparam sad_t FRAME_SAD [3] = '{5'd2, 5'd18, 5'd2};
    localparam logic [1:0] FRAME_LED [3] = '{2'b01, 2'b10, 2'b00};

    logic clk;
    logic reset;
    gray_t gray_left;
    gray_t gray_right;
    hamming_t hamming;
    sad_t sad;
    coord_t x_pixel;
    coord_t y_pixel;
    logic h_sync;
    logic v_sync;
    rgb565_t rgb;
    logic [NUM_ZONES-1:0] led;
    logic buzz;

    logic [15:0] lfsr;
    rgb565_t exp_rgb;
    logic exp_h;
    logic exp_v;
    logic [1:0] exp_led;
    logic [1:0] led_pipe;
    int exp_x;
    int exp_y;
    int n_black [NUM_ZONES];
    int n_orange [NUM_ZONES];
    int n_red [NUM_ZONES];
    int sev [NUM_ZONES];
    int frames_done;
    int buzz_left;
    bit rise_seen;
    bit fall_seen;
    logic prev_buzz;

    tb_clock_gen #(
        .PERIOD       (100),
        .RESET_CYCLES (4)
    ) u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    stereo_alarm_top u_stereo_alarm_top (
        .clk        (clk),
        .reset      (reset),
        .gray_left  (gray_left),
        .gray_right (gray_right),
        .hamming    (hamming),
        .sad        (sad),
        .x_pixel    (x_pixel),
        .y_pixel    (y_pixel),
        .h_sync     (h_sync),
        .v_sync     (v_sync),
        .rgb        (rgb),
        .led        (led),
        .buzz       (buzz)
    );

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            value = {value[6:0], lfsr[0]};
        end
    endtask

    task automatic fail_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, expected);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic fail_text(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    function automatic rgb565_t heat_color(input int code, input bit use_sad);
        int edge_val;
        for (int i = 0; i < 6; i++) begin
            edge_val = use_sad ? SAD_EDGE[i] : HAM_EDGE[i];
            if (code <= edge_val) begin
                return HEAT[i];
            end
        end
        return COLOR_BLACK;
    endfunction

    function automatic rgb565_t model_rgb(input int x, input int y, input gray_t gl,
                                          input gray_t gr, input hamming_t h, input sad_t s);
        gray_t g;
        if (x >= H_ACTIVE || y >= V_ACTIVE) begin
            return COLOR_BLACK;
        end
        if (y < QUAD_H) begin
            g = (x < QUAD_W) ? gl : gr;
            return {g[7:3], g[7:2], g[7:3]};
        end
        return (x < QUAD_W) ? heat_color(int'(h), 1'b0) : heat_color(int'(s), 1'b1);
    endfunction

    function automatic bit in_zone(input int z, input int x, input int y);
        return x >= int'(ZONE_X_LO[z]) && x <= int'(ZONE_X_HI[z]) &&
               y >= int'(ZONE_Y_LO) && y <= int'(ZONE_Y_HI);
    endfunction

    function automatic int judge(input int nb, input int no, input int nr);
        if (nb >= int'(BLACK_LIMIT)) begin
            return 3;
        end
        if (no >= int'(ORANGE_LIMIT) || nr >= int'(RED_LIMIT)) begin
            return 2;
        end
        return 0;
    endfunction

    task automatic check_outputs();
        if (reset) begin
            assert (rgb == COLOR_BLACK) else fail_value("rgb", 32'(rgb), 32'(COLOR_BLACK));
            assert (h_sync == 1'b1) else fail_value("h_sync", 32'(h_sync), 32'd1);
            assert (v_sync == 1'b1) else fail_value("v_sync", 32'(v_sync), 32'd1);
            assert (led == 2'b00) else fail_value("led", 32'(led), 32'd0);
            assert (buzz == 1'b0) else fail_value("buzz", 32'(buzz), 32'd0);
            assert (x_pixel == '0) else fail_value("x_pixel", 32'(x_pixel), 32'd0);
            assert (y_pixel == '0) else fail_value("y_pixel", 32'(y_pixel), 32'd0);
            exp_x = 0;
            exp_y = 0;
        end else begin
            // scan position moves one pixel per clock
            if (exp_x == H_TOTAL - 1) begin
                exp_x = 0;
                exp_y = (exp_y == V_TOTAL - 1) ? 0 : exp_y + 1;
            end else begin
                exp_x++;
            end
            assert (int'(x_pixel) == exp_x)
                else fail_value("x_pixel", 32'(x_pixel), 32'(exp_x));
            assert (int'(y_pixel) == exp_y)
                else fail_value("y_pixel", 32'(y_pixel), 32'(exp_y));
            assert (rgb == exp_rgb) else fail_value("rgb", 32'(rgb), 32'(exp_rgb));
            assert (h_sync == exp_h) else fail_value("h_sync", 32'(h_sync), 32'(exp_h));
            assert (v_sync == exp_v) else fail_value("v_sync", 32'(v_sync), 32'(exp_v));
            assert (led == exp_led) else fail_value("led", 32'(led), 32'(exp_led));
            // quiet zones one cycle back keep the buzzer silent
            if (exp_led == 2'b00) begin
                assert (buzz == 1'b0) else fail_value("buzz", 32'(buzz), 32'd0);
            end
            if (buzz_left > 0) begin
                rise_seen = rise_seen || (buzz && !prev_buzz);
                fall_seen = fall_seen || (!buzz && prev_buzz);
                buzz_left--;
                if (buzz_left == 0) begin
                    assert (rise_seen && fall_seen)
                        else fail_text("buzz did not rise and fall within one beep period");
                end
            end
        end
        prev_buzz = buzz;
    endtask

    // one pixel: check last cycle, drive this position, update the model
    task automatic step_cycle();
        logic [7:0] r;
        int xi;
        int yi;
        int f;
        int window;
        @(negedge clk);
        check_outputs();
        xi = int'(x_pixel);
        yi = int'(y_pixel);
        f = (frames_done > 2) ? 2 : frames_done;
        take_bits(8, r);
        gray_left = r;
        take_bits(8, r);
        gray_right = r;
        if (in_zone(0, xi, yi) || in_zone(1, xi, yi)) begin
            hamming = FRAME_HAM[f];
            sad = FRAME_SAD[f];
        end else begin
            take_bits(6, r);
            hamming = r[5:0];
            take_bits(5, r);
            sad = r[4:0];
        end
        exp_rgb = model_rgb(xi, yi, gray_left, gray_right, hamming, sad);
        exp_h = !(xi >= H_SYNC_START && xi <= H_SYNC_END);
        exp_v = !(yi >= V_SYNC_START && yi <= V_SYNC_END);
        for (int z = 0; z < NUM_ZONES; z++) begin
            if (in_zone(z, xi, yi)) begin
                n_black[z] += (exp_rgb == COLOR_BLACK) ? 1 : 0;
                n_orange[z] += (exp_rgb == COLOR_ORANGE) ? 1 : 0;
                n_red[z] += (exp_rgb == COLOR_RED) ? 1 : 0;
            end
        end
        if (!reset && xi == H_ACTIVE - 1 && yi == V_ACTIVE - 1) begin
            for (int z = 0; z < NUM_ZONES; z++) begin
                sev[z] = judge(n_black[z], n_orange[z], n_red[z]);
                n_black[z] = 0;
                n_orange[z] = 0;
                n_red[z] = 0;
            end
            assert ({sev[1] != 0, sev[0] != 0} == FRAME_LED[f])
                else fail_text("frame stimulus did not give the intended zone alarms");
            window = 0;
            if (sev[0] == 3 || sev[1] == 3) begin
                window = BEEP_FAST;
            end else if (sev[0] != 0 || sev[1] != 0) begin
                window = BEEP_SLOW;
            end
            // severity moves next cycle, buzz one cycle after that
            buzz_left = (window > 0) ? window + 2 : 0;
            rise_seen = 1'b0;
            fall_seen = 1'b0;
            frames_done++;
        end
        exp_led = led_pipe;
        led_pipe = {sev[1] != 0, sev[0] != 0};
    endtask

    initial begin
        int cycles;
        gray_left = '0;
        gray_right = '0;
        hamming = '0;
        sad = '0;
        lfsr = 16'd72;
        exp_rgb = COLOR_BLACK;
        exp_h = 1'b1;
        exp_v = 1'b1;
        exp_led = 2'b00;
        led_pipe = 2'b00;
        exp_x = 0;
        exp_y = 0;
        for (int z = 0; z < NUM_ZONES; z++) begin
            n_black[z] = 0;
            n_orange[z] = 0;
            n_red[z] = 0;
            sev[z] = 0;
        end
        frames_done = 0;
        buzz_left = 0;
        rise_seen = 1'b0;
        fall_seen = 1'b0;
        prev_buzz = 1'b0;
        cycles = 0;
        while (frames_done < 3 && cycles < CYCLE_LIMIT) begin
            step_cycle();
            cycles++;
        end
        if (frames_done < 3) begin
            fail_text("timed out before three frames completed");
        end else begin
            // frame C must stay silent for a full slow beep period
            repeat (BEEP_SLOW + 4) step_cycle();
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: vga_scan.sv
`timescale 1ns/10ps
`default_nettype none

module vga_scan (
    input  wire logic                      clk,
    input  wire logic                      reset,
    output stereo_alarm_pkg::coord_t       x_pixel,
    output stereo_alarm_pkg::coord_t       y_pixel,
    output logic                           h_sync,
    output logic                           v_sync
);
    import stereo_alarm_pkg::*;

    logic line_end;
    logic frame_end;

    assign line_end  = (x_pixel == coord_t'(H_TOTAL - 1));
    assign frame_end = (y_pixel == coord_t'(V_TOTAL - 1));

    // x wraps every line, y steps at line end
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            x_pixel <= '0;
            y_pixel <= '0;
        end else if (line_end) begin
            x_pixel <= '0;
            if (frame_end) begin
                y_pixel <= '0;
            end else begin
                y_pixel <= y_pixel + 1'b1;
            end
        end else begin
            x_pixel <= x_pixel + 1'b1;
        end
    end

    // syncs are active low and lag the count by one cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            h_sync <= 1'b1;
            v_sync <= 1'b1;
        end else begin
            h_sync <= !(x_pixel >= coord_t'(H_SYNC_START) && x_pixel <= coord_t'(H_SYNC_END));
            v_sync <= !(y_pixel >= coord_t'(V_SYNC_START) && y_pixel <= coord_t'(V_SYNC_END));
        end
    end

endmodule

`default_nettype wire

// File: zone_monitor.sv
`timescale 1ns/10ps
`default_nettype none

module zone_monitor #(
    parameter int ZONE = 0
) (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  stereo_alarm_pkg::coord_t         x_pixel,
    input  stereo_alarm_pkg::coord_t         y_pixel,
    input  stereo_alarm_pkg::pixel_class_t   pix_class,
    output stereo_alarm_pkg::severity_t      severity
);
    import stereo_alarm_pkg::*;

    logic   in_window;
    logic   frame_end;
    count_t black_cnt;
    count_t orange_cnt;
    count_t red_cnt;
    count_t black_next;
    count_t orange_next;
    count_t red_next;

    assign in_window = (x_pixel >= ZONE_X_LO[ZONE]) && (x_pixel <= ZONE_X_HI[ZONE]) &&
                       (y_pixel >= ZONE_Y_LO) && (y_pixel <= ZONE_Y_HI);
    assign frame_end = (x_pixel == coord_t'(H_ACTIVE - 1)) &&
                       (y_pixel == coord_t'(V_ACTIVE - 1));

    // counts including the current pixel
    assign black_next  = black_cnt  + count_t'(in_window && pix_class == CLASS_BLACK);
    assign orange_next = orange_cnt + count_t'(in_window && pix_class == CLASS_ORANGE);
    assign red_next    = red_cnt    + count_t'(in_window && pix_class == CLASS_RED);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            black_cnt  <= '0;
            orange_cnt <= '0;
            red_cnt    <= '0;
            severity   <= SEV_QUIET;
        end else if (frame_end) begin
            // judge the finished frame, then start over
            if (black_next >= BLACK_LIMIT) begin
                severity <= SEV_DANGER;
            end else if (orange_next >= ORANGE_LIMIT || red_next >= RED_LIMIT) begin
                severity <= SEV_WARN;
            end else begin
                severity <= SEV_QUIET;
            end
            black_cnt  <= '0;
            orange_cnt <= '0;
            red_cnt    <= '0;
        end else begin
            black_cnt  <= black_next;
            orange_cnt <= orange_next;
            red_cnt    <= red_next;
        end
    end

endmodule

`default_nettype wire
